/* Bender.yml */
package:
  name: ask_link

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/ask_pkg.sv
      - logic/clk_enables.sv
      - logic/ask_symbol_source.sv
      - logic/fir_filter.sv
      - logic/phase_select.sv
      - logic/decision_stats.sv
      - logic/ask_link_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/ask_link_tb.sv

/* include/ask_consts.svh */
`ifndef ASK_CONSTS_SVH
`define ASK_CONSTS_SVH

// ************************************************************
// Rates
// ************************************************************

// sys_clk cycles per sample
`define SAMPLE_DIV 4
// Samples per symbol
`define SAMPLES_PER_SYM 4
// Symbols per measurement block is 2**BLOCK_LOG2
`define BLOCK_LOG2 6

// ************************************************************
// Symbol source
// ************************************************************

// Fibonacci taps 16, 14, 13, 11
`define LFSR_POLY 16'hB400
// Any nonzero start value
`define LFSR_SEED 16'hACE1

// 4-ASK magnitudes in 1s17, 3/4 and 1/4
`define LEVEL_OUTER 18'sd98304
`define LEVEL_INNER 18'sd32768

// ************************************************************
// Filters and receiver
// ************************************************************

// Rectangular tap of 1/4 in 1s17
`define FIR_TAP 18'sd32768
// Midpoint of inner and outer levels after both filters, 1/8
`define REF_INIT 18'sd16384
// Symbol periods from issue to decision
`define SYM_LATENCY 2

`endif

/* logic/ask_link_top.sv */
`timescale 1ns/1ps

module ask_link_top (
	input  logic                 sys_clk,
	input  logic                 arst_n,
	input  ask_pkg::scale_t      scale,
	input  ask_pkg::phase_t      phase,
	output ask_pkg::sym_t        tx_sym,
	output ask_pkg::decision_t   decision,
	output logic                 dec_valid,
	output ask_pkg::link_stats_t stats,
	output logic                 stats_valid
);
	import ask_pkg::*;

	logic       sam_en;
	logic       sym_en;
	logic [1:0] sam_idx;
	sample_t    tx_level;
	sample_t    tx_in;
	sample_t    tx_out;
	sample_t    rx_out;
	sample_t    dec_var;

	// ************************************************************
	// Rate strobes and symbol source
	// ************************************************************

	clk_enables i_clk_enables (
		.sys_clk (sys_clk),
		.arst_n  (arst_n),
		.sam_en  (sam_en),
		.sym_en  (sym_en)
	);

	ask_symbol_source i_source (
		.sys_clk  (sys_clk),
		.arst_n   (arst_n),
		.sym_en   (sym_en),
		.scale    (scale),
		.tx_sym   (tx_sym),
		.tx_level (tx_level)
	);

	// Sample index within the symbol, restarts at each sym_en
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			sam_idx <= '0;
		end else if (sym_en) begin
			sam_idx <= '0;
		end else if (sam_en) begin
			sam_idx <= sam_idx + 2'd1;
		end
	end

	// Upsample by zero insertion, one nonzero sample per symbol
	// Slot 2 puts the matched filter peak on phase 0
	assign tx_in = (sam_idx == 2'd2) ? tx_level : '0;

	// ************************************************************
	// Transmit and matched filters
	// ************************************************************

	fir_filter i_tx_filter (
		.sys_clk (sys_clk),
		.arst_n  (arst_n),
		.sam_en  (sam_en),
		.x_in    (tx_in),
		.y       (tx_out)
	);

	fir_filter i_rx_filter (
		.sys_clk (sys_clk),
		.arst_n  (arst_n),
		.sam_en  (sam_en),
		.x_in    (tx_out),
		.y       (rx_out)
	);

	// Decision variable and measurement
	phase_select i_phase_select (
		.sys_clk (sys_clk),
		.arst_n  (arst_n),
		.sam_en  (sam_en),
		.sym_en  (sym_en),
		.phase   (phase),
		.x_in    (rx_out),
		.dec_var (dec_var)
	);

	decision_stats i_decision_stats (
		.sys_clk     (sys_clk),
		.arst_n      (arst_n),
		.sym_en      (sym_en),
		.dec_var     (dec_var),
		.decision    (decision),
		.dec_valid   (dec_valid),
		.stats       (stats),
		.stats_valid (stats_valid)
	);

endmodule

/* logic/ask_pkg.sv */
package ask_pkg;

	// Signed 1s17 sample
	typedef logic signed [17:0] sample_t;

	// Symbol index, 0..3 maps to -3/4, -1/4, +1/4, +3/4
	typedef logic [1:0] sym_t;

	// Block sums
	typedef logic signed [31:0] acc_t;
	typedef logic [55:0] sq_acc_t;

	// Right shift applied to the transmit level
	typedef logic [2:0] scale_t;

	// Matched filter sample phase
	typedef logic [1:0] phase_t;

	// One measurement block result
	typedef struct packed {
		sample_t ref_lvl;
		acc_t    err_sum;
		sq_acc_t err_sq_sum;
	} link_stats_t;

	// Per symbol slicer result
	typedef struct packed {
		sym_t    sym;
		sample_t err;
	} decision_t;

endpackage

/* logic/ask_symbol_source.sv */
`timescale 1ns/1ps
`include "ask_consts.svh"

module ask_symbol_source (
	input  logic             sys_clk,
	input  logic             arst_n,
	input  logic             sym_en,
	input  ask_pkg::scale_t  scale,
	output ask_pkg::sym_t    tx_sym,
	output ask_pkg::sample_t tx_level
);
	import ask_pkg::*;

	logic [15:0] lfsr;
	logic [15:0] lfsr_next;
	sym_t        sym_next;
	sample_t     level;

	// One Fibonacci shift, feedback enters at the LSB
	function automatic logic [15:0] lfsr_step(input logic [15:0] cur);
		logic fb;
		fb = ^(cur & `LFSR_POLY);
		return {cur[14:0], fb};
	endfunction

	// Two shifts per symbol, so both symbol bits are fresh
	assign lfsr_next = lfsr_step(lfsr_step(lfsr));
	assign sym_next  = lfsr_next[1:0];

	// Gray order not needed here, plain ascending levels
	always_comb begin
		case (sym_next)
			2'd0:    level = -`LEVEL_OUTER;
			2'd1:    level = -`LEVEL_INNER;
			2'd2:    level = `LEVEL_INNER;
			default: level = `LEVEL_OUTER;
		endcase
	end

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			lfsr     <= `LFSR_SEED;
			tx_sym   <= '0;
			tx_level <= '0;
		end else if (sym_en) begin
			lfsr     <= lfsr_next;
			tx_sym   <= sym_next;
			// Arithmetic shift keeps the sign
			tx_level <= level >>> scale;
		end
	end

endmodule

/* logic/clk_enables.sv */
`timescale 1ns/1ps
`include "ask_consts.svh"

module clk_enables (
	input  logic sys_clk,
	input  logic arst_n,
	output logic sam_en,
	output logic sym_en
);

	// Cycle within a sample, sample within a symbol
	logic [1:0] sam_cnt;
	logic [1:0] sym_cnt;
	logic       sam_last;

	assign sam_last = (sam_cnt == 2'(`SAMPLE_DIV - 1));

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			sam_cnt <= '0;
			sym_cnt <= '0;
			sam_en  <= 1'b0;
			sym_en  <= 1'b0;
		end else begin
			sam_cnt <= sam_last ? '0 : sam_cnt + 2'd1;
			// Symbol count only moves on sample boundaries
			if (sam_last) begin
				sym_cnt <= (sym_cnt == 2'(`SAMPLES_PER_SYM - 1)) ? '0 : sym_cnt + 2'd1;
			end
			// Registered strobes, sym_en lands on a sam_en cycle
			sam_en <= sam_last;
			sym_en <= sam_last && (sym_cnt == 2'(`SAMPLES_PER_SYM - 1));
		end
	end

endmodule

/* logic/decision_stats.sv */
`timescale 1ns/1ps
`include "ask_consts.svh"

module decision_stats (
	input  logic                 sys_clk,
	input  logic                 arst_n,
	input  logic                 sym_en,
	input  ask_pkg::sample_t     dec_var,
	output ask_pkg::decision_t   decision,
	output logic                 dec_valid,
	output ask_pkg::link_stats_t stats,
	output logic                 stats_valid
);
	import ask_pkg::*;

	logic                   sym_d;
	logic                   blk_end;
	logic [`BLOCK_LOG2-1:0] blk_cnt;
	sample_t                ref_lvl;
	sample_t                ref_half;
	sym_t                   slice;
	sample_t                map_lvl;
	logic signed [18:0]     err_wide;
	sample_t                err_now;
	logic signed [35:0]     err_sq;
	acc_t                   dv_mag;
	acc_t                   mag_sum;
	acc_t                   err_sum;
	sq_acc_t                sq_sum;

	// ************************************************************
	// Slicer and reference mapper
	// ************************************************************

	// Thresholds at 0 and +-ref_lvl
	always_comb begin
		if (dec_var >= ref_lvl) begin
			slice = 2'd3;
		end else if (dec_var >= 18'sd0) begin
			slice = 2'd2;
		end else if (dec_var >= -ref_lvl) begin
			slice = 2'd1;
		end else begin
			slice = 2'd0;
		end
	end

	// ref_lvl is the average magnitude, levels sit at 1/2 and 3/2 of it
	assign ref_half = ref_lvl >>> 1;

	always_comb begin
		case (slice)
			2'd3:    map_lvl = ref_lvl + ref_half;
			2'd2:    map_lvl = ref_half;
			2'd1:    map_lvl = -ref_half;
			default: map_lvl = -(ref_lvl + ref_half);
		endcase
	end

	// Error with one guard bit, clamped back to 1s17
	assign err_wide = 19'(dec_var) - 19'(map_lvl);

	always_comb begin
		if (err_wide > 19'sd131071) begin
			err_now = 18'sh1FFFF;
		end else if (err_wide < -19'sd131072) begin
			err_now = 18'sh20000;
		end else begin
			err_now = sample_t'(err_wide);
		end
	end

	assign err_sq = err_now * err_now;
	assign dv_mag = dec_var[17] ? -acc_t'(dec_var) : acc_t'(dec_var);

	// ************************************************************
	// Decision register
	// ************************************************************

	// dec_var is latched on sym_en, so act one cycle later
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			sym_d     <= 1'b0;
			dec_valid <= 1'b0;
			decision  <= '0;
		end else begin
			sym_d     <= sym_en;
			dec_valid <= sym_d;
			if (sym_d) begin
				decision <= '{sym: slice, err: err_now};
			end
		end
	end

	// ************************************************************
	// Block accumulators
	// ************************************************************

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			blk_cnt <= '0;
			blk_end <= 1'b0;
			mag_sum <= '0;
			err_sum <= '0;
			sq_sum  <= '0;
		end else begin
			// Last symbol of the block flags the unload
			blk_end <= sym_d && (blk_cnt == '1);
			if (sym_d) begin
				blk_cnt <= blk_cnt + 1'b1;
			end
			if (blk_end) begin
				mag_sum <= '0;
				err_sum <= '0;
				sq_sum  <= '0;
			end else if (sym_d) begin
				mag_sum <= mag_sum + dv_mag;
				err_sum <= err_sum + acc_t'(err_now);
				sq_sum  <= sq_sum + sq_acc_t'($unsigned(err_sq));
			end
		end
	end

	// Unload one cycle after the closing decision
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			ref_lvl     <= `REF_INIT;
			stats       <= '0;
			stats_valid <= 1'b0;
		end else begin
			stats_valid <= blk_end;
			if (blk_end) begin
				// Mean magnitude over the block
				ref_lvl          <= sample_t'(mag_sum >>> `BLOCK_LOG2);
				stats.ref_lvl    <= sample_t'(mag_sum >>> `BLOCK_LOG2);
				stats.err_sum    <= err_sum;
				stats.err_sq_sum <= sq_sum;
			end
		end
	end

endmodule

/* logic/fir_filter.sv */
`timescale 1ns/1ps
`include "ask_consts.svh"

module fir_filter (
	input  logic             sys_clk,
	input  logic             arst_n,
	input  logic             sam_en,
	input  ask_pkg::sample_t x_in,
	output ask_pkg::sample_t y
);
	import ask_pkg::*;

	// Previous three inputs, current input is the fourth tap
	sample_t            dly [0:2];
	logic signed [19:0] tap_sum;
	logic signed [37:0] prod;
	logic signed [37:0] prod_rnd;
	logic signed [20:0] y_wide;
	sample_t            y_sat;

	// All taps equal, so add first and multiply once
	assign tap_sum = 20'(x_in) + 20'(dly[0]) + 20'(dly[1]) + 20'(dly[2]);
	assign prod    = tap_sum * `FIR_TAP;

	// Round half up at bit 16, then drop the 17 fraction bits of the tap
	assign prod_rnd = prod + 38'sd65536;
	assign y_wide   = 21'(prod_rnd >>> 17);

	// Clamp to the 1s17 range
	always_comb begin
		if (y_wide > 21'sd131071) begin
			y_sat = 18'sh1FFFF;
		end else if (y_wide < -21'sd131072) begin
			y_sat = 18'sh20000;
		end else begin
			y_sat = sample_t'(y_wide);
		end
	end

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			dly[0] <= '0;
			dly[1] <= '0;
			dly[2] <= '0;
			y      <= '0;
		end else if (sam_en) begin
			dly[0] <= x_in;
			dly[1] <= dly[0];
			dly[2] <= dly[1];
			y      <= y_sat;
		end
	end

endmodule

/* logic/phase_select.sv */
`timescale 1ns/1ps

module phase_select (
	input  logic             sys_clk,
	input  logic             arst_n,
	input  logic             sam_en,
	input  logic             sym_en,
	input  ask_pkg::phase_t  phase,
	input  ask_pkg::sample_t x_in,
	output ask_pkg::sample_t dec_var
);
	import ask_pkg::*;

	// Matched filter history at the sample rate
	sample_t mdly [0:2];

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			mdly[0] <= '0;
			mdly[1] <= '0;
			mdly[2] <= '0;
		end else if (sam_en) begin
			mdly[0] <= x_in;
			mdly[1] <= mdly[0];
			mdly[2] <= mdly[1];
		end
	end

	// Phase 0 takes the newest sample, phase 3 the oldest
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			dec_var <= '0;
		end else if (sym_en) begin
			case (phase)
				2'd1:    dec_var <= mdly[0];
				2'd2:    dec_var <= mdly[1];
				2'd3:    dec_var <= mdly[2];
				default: dec_var <= x_in;
			endcase
		end
	end

endmodule

/* sim.f */
+incdir+include
logic/ask_pkg.sv
logic/clk_enables.sv
logic/ask_symbol_source.sv
logic/fir_filter.sv
logic/phase_select.sv
logic/decision_stats.sv
logic/ask_link_top.sv
verification/ask_link_tb.sv

/* verification/ask_link_tb.sv */
`timescale 1ns/1ps
`include "ask_consts.svh"

module ask_link_tb;
	import ask_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int TIMEOUT    = 20000;
	localparam int SYM_CYCLES = `SAMPLE_DIV * `SAMPLES_PER_SYM;
	localparam int BLOCK_LEN  = 1 << `BLOCK_LOG2;

	// One stimulus row
	typedef struct packed {
		scale_t     scale;
		phase_t     phase;
		logic [3:0] blocks;
		logic       exp_isi;
	} row_t;

	logic        sys_clk = 1'b0;
	logic        arst_n;
	scale_t      scale;
	phase_t      phase;
	sym_t        tx_sym;
	decision_t   decision;
	logic        dec_valid;
	link_stats_t stats;
	logic        stats_valid;

	row_t rows [0:3];
	int   blk_ref [0:3];
	int   n_rows;
	int   checks;
	int   errors;
	bit   timed_out;
	int   r;

	always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

	ask_link_top i_dut (
		.sys_clk     (sys_clk),
		.arst_n      (arst_n),
		.scale       (scale),
		.phase       (phase),
		.tx_sym      (tx_sym),
		.decision    (decision),
		.dec_valid   (dec_valid),
		.stats       (stats),
		.stats_valid (stats_valid)
	);

	// ************************************************************
	// Reference model
	// ************************************************************

	// Taps 16, 14, 13, 11 counted from 1 with feedback into bit 0
	function automatic logic [15:0] shift_lfsr(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// Symbols 0..3 give -3, -1, +1, +3 times the inner level
	function automatic int level_of(input sym_t s);
		return (2 * int'(s) - 3) * int'(`LEVEL_INNER);
	endfunction

	// Decision regions split at 0 and +-r
	function automatic sym_t slice_of(input int dv, input int r);
		if (dv >= r)
			return 2'd3;
		if (dv >= 0)
			return 2'd2;
		if (dv >= -r)
			return 2'd1;
		return 2'd0;
	endfunction

	// Ideal points at half and one and a half times the mean magnitude
	function automatic int ref_point(input sym_t s, input int r);
		int half;
		int mag;
		half = r / 2;
		mag  = (s == 2'd0 || s == 2'd3) ? r + half : half;
		return s[1] ? mag : -mag;
	endfunction

	// ************************************************************
	// Helpers
	// ************************************************************

	task automatic check_that(input bit ok, input string what);
		checks++;
		assert (ok) else begin
			errors++;
			$display("[FAIL] %0d ns: %s", $time, what);
		end
	endtask

	task automatic add_row(input int s, input int p, input int b, input bit isi);
		rows[n_rows].scale   = scale_t'(s);
		rows[n_rows].phase   = phase_t'(p);
		rows[n_rows].blocks  = 4'(b);
		rows[n_rows].exp_isi = isi;
		blk_ref[n_rows]      = 0;
		n_rows++;
	endtask

	task automatic apply_reset(input scale_t s, input phase_t p);
		@(posedge sys_clk);
		arst_n <= 1'b0;
		scale  <= s;
		phase  <= p;
		repeat (2) @(posedge sys_clk);
		check_that(!dec_valid && !stats_valid && tx_sym == '0 && decision == '0
			&& stats == '0, "outputs not cleared while reset is held");
		arst_n <= 1'b1;
	endtask

	// Wait for the next dec_valid while stats_valid stays low
	task automatic wait_decision(output bit got);
		int n;
		got = 1'b0;
		n   = 0;
		while (!got && n < TIMEOUT) begin
			@(negedge sys_clk);
			n++;
			if (dec_valid) begin
				got = 1'b1;
			end else begin
				check_that(!stats_valid, "stats_valid outside a block end");
			end
		end
	endtask

	task automatic run_row(input int r);
		logic [15:0] lfsr;
		sym_t        sym_q [$];
		sym_t        new_sym;
		sym_t        old_sym;
		sym_t        exp_slice;
		int          n_dec;
		int          d;
		int          dv;
		int          ref_lvl;
		int          exp_err;
		int          mag_sum;
		int          err_acc;
		longint      sq_acc;
		bit          got;
		bit          have_sym;
		time         t_prev;
		time         t_now;

		lfsr    = `LFSR_SEED;
		ref_lvl = `REF_INIT;
		mag_sum = 0;
		err_acc = 0;
		sq_acc  = 0;
		n_dec   = rows[r].blocks * BLOCK_LEN;
		$display("Row %0d: scale %0d, phase %0d, %0d blocks", r, rows[r].scale,
			rows[r].phase, rows[r].blocks);
		apply_reset(rows[r].scale, rows[r].phase);
		t_prev = $time;
		for (d = 1; d <= n_dec && !timed_out; d++) begin
			wait_decision(got);
			if (!got) begin
				$display("Timeout: no dec_valid within %0d cycles in row %0d", TIMEOUT, r);
				timed_out = 1'b1;
			end else begin
				t_now = $time;
				// Nothing decided inside the first symbol period
				if (d == 1) begin
					check_that(t_now - t_prev >= SYM_CYCLES * CLK_PERIOD,
						"dec_valid within the first symbol period");
				end else begin
					check_that(t_now - t_prev == SYM_CYCLES * CLK_PERIOD,
						$sformatf("dec_valid gap %0d ns", t_now - t_prev));
				end
				t_prev = t_now;
				// Symbol just issued by the source
				lfsr    = shift_lfsr(shift_lfsr(lfsr));
				new_sym = lfsr[1:0];
				check_that(tx_sym == new_sym, $sformatf("tx_sym %0d, model %0d", tx_sym,
					new_sym));
				sym_q.push_back(new_sym);
				have_sym = (sym_q.size() > `SYM_LATENCY);
				old_sym  = 2'd0;
				if (have_sym) begin
					old_sym = sym_q.pop_front();
				end
				if (!rows[r].exp_isi) begin
					// Triangle peak equals a quarter of the scaled level
					dv        = have_sym ? (level_of(old_sym) >>> rows[r].scale) / 4 : 0;
					exp_slice = slice_of(dv, ref_lvl);
					exp_err   = dv - ref_point(exp_slice, ref_lvl);
					check_that(decision.sym == exp_slice, $sformatf(
						"decision %0d sym %0d, expected %0d", d, decision.sym, exp_slice));
					check_that(int'(decision.err) == exp_err, $sformatf(
						"decision %0d err %0d, expected %0d", d, decision.err, exp_err));
					if (d > BLOCK_LEN) begin
						check_that(decision.sym == old_sym, $sformatf(
							"decision %0d sym %0d, sent %0d", d, decision.sym, old_sym));
					end
					mag_sum += (dv < 0) ? -dv : dv;
					err_acc += exp_err;
					sq_acc  += longint'(exp_err) * exp_err;
				end
				if (d % BLOCK_LEN == 0) begin
					@(negedge sys_clk);
					check_that(stats_valid, "stats_valid missing after block end");
					if (!rows[r].exp_isi) begin
						check_that(int'(stats.ref_lvl) == mag_sum / BLOCK_LEN, $sformatf(
							"ref_lvl %0d, expected %0d", stats.ref_lvl, mag_sum / BLOCK_LEN));
						check_that(int'(stats.err_sum) == err_acc, $sformatf(
							"err_sum %0d, expected %0d", stats.err_sum, err_acc));
						check_that(longint'(stats.err_sq_sum) == sq_acc, $sformatf(
							"err_sq_sum %0d, expected %0d", stats.err_sq_sum, sq_acc));
						ref_lvl = mag_sum / BLOCK_LEN;
						// Reported level of the second block
						if (d == 2 * BLOCK_LEN) begin
							blk_ref[r] = int'(stats.ref_lvl);
						end
						mag_sum = 0;
						err_acc = 0;
						sq_acc  = 0;
					end else if (d == 2 * BLOCK_LEN) begin
						// Neighbor symbol leaks into the sample
						check_that(stats.err_sq_sum != '0, "err_sq_sum zero at a wrong phase");
					end
				end
			end
		end
	endtask

	// Scaled rows against row 0
	task automatic compare_scales();
		int i;
		for (i = 1; i < n_rows; i++) begin
			if (!rows[i].exp_isi) begin
				check_that((blk_ref[i] << rows[i].scale) == blk_ref[0], $sformatf(
					"row %0d ref_lvl %0d against %0d", i, blk_ref[i], blk_ref[0]));
			end
		end
	endtask

	// ************************************************************
	// Main sequence
	// ************************************************************

	initial begin
		arst_n    = 1'b0;
		scale     = '0;
		phase     = '0;
		checks    = 0;
		errors    = 0;
		timed_out = 1'b0;
		n_rows    = 0;
		// Row 0 is the unscaled reference
		add_row(0, 0, 3, 1'b0);
		add_row(1, 0, 3, 1'b0);
		add_row(2, 0, 3, 1'b0);
		add_row(0, 2, 2, 1'b1);
		for (r = 0; r < n_rows && !timed_out; r++) begin
			run_row(r);
		end
		if (!timed_out) begin
			compare_scales();
		end
		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timed_out);
		if (errors == 0 && !timed_out) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
